/* hw/dma_rearm_defines.svh */
`ifndef DMA_REARM_DEFINES_SVH
`define DMA_REARM_DEFINES_SVH

// Bus widths
`define DATA_W 32
`define ADDR_W 32
`define REG_NUM 32

// Host register map, index 0 is the top chip-enable bit
`define REG_LEN 0
`define REG_PUSH 1
`define REG_BASE 2
`define REG_COUNT 3
`define REG_LEVEL 4

`define QUEUE_DEPTH 8
`define WINDOW_BYTES 32'h0040_0000

// Descriptor program targets, in issue order
`define DESC_ADDR_0 32'h7900_000C
`define DESC_ADDR_1 32'h4040_0030
`define DESC_ADDR_2 32'h4040_0034
`define DESC_ADDR_3 32'h4040_0048
`define DESC_ADDR_4 32'h4040_0058
`define DESC_ADDR_5 32'h7900_000C
`define DESC_CTRL_A 32'h0000_1001
`define DESC_CTRL_B 32'h0000_1000
`define DESC_MASK 32'hFFFF_FFFF
`define DESC_KICK_BASE 32'h0001_0000
`define DESC_COUNT 6

`endif

/* hw/dma_rearm_reg_pkg.sv */
`include "dma_rearm_defines.svh"

package dma_rearm_reg_pkg;

  // Register number decoded from the chip enables
  typedef logic [4:0] reg_index_t;

  // One host write, strobe valid for a single cycle
  typedef struct packed {
    logic               wr;
    reg_index_t         idx;
    logic [`DATA_W-1:0] data;
  } reg_write_t;

  // Sequencer state as seen by the host
  typedef struct packed {
    logic [`DATA_W-1:0] len;
    logic [`ADDR_W-1:0] base;
    logic [`DATA_W-1:0] count;
    logic [3:0]         level;
  } seq_status_t;

endpackage

/* hw/dma_rearm_axi_pkg.sv */
`include "dma_rearm_defines.svh"

package dma_rearm_axi_pkg;

  // Master side of the AXI4-Lite write channels
  typedef struct packed {
    logic [`ADDR_W-1:0] awaddr;
    logic               awvalid;
    logic [`DATA_W-1:0] wdata;
    logic               wvalid;
    logic               bready;
  } axi_write_req_t;

  // Slave side of the AXI4-Lite write channels
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
  } axi_write_rsp_t;

  // One DMA block to program
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] len_words;
  } desc_req_t;

endpackage

/* hw/reg_decode.sv */
`include "dma_rearm_defines.svh"

module reg_decode
  import dma_rearm_reg_pkg::*;
(
  input  logic               M_AXI_ACLK,
  input  logic               M_AXI_ARESETN,
  input  logic [`REG_NUM-1:0] bus_wr_ce,
  input  logic [`REG_NUM-1:0] bus_rd_ce,
  input  logic [`DATA_W-1:0] bus_wdata,
  input  seq_status_t        status,
  output reg_write_t         reg_wr,
  output logic [`DATA_W-1:0] bus_rdata,
  output logic               bus_wr_ack,
  output logic               bus_rd_ack
);

  logic [`REG_NUM-1:0] ce_sel;
  reg_index_t          ce_idx;
  reg_index_t          idx_q;
  logic [`DATA_W-1:0]  wdata_q;
  logic [`DATA_W-1:0]  rd_mux;
  logic                sel_q;
  logic                sel_d;
  logic                sel_2d;
  logic                rd_q;
  logic                ce_first;
  logic                ack_s;

  // Read enables win over write enables
  assign ce_sel   = (bus_rd_ce == '0) ? bus_wr_ce : bus_rd_ce;
  assign ce_first = (|ce_sel) & ~sel_q;
  assign ack_s    = sel_d & ~sel_2d;

  // One-hot to index, anything else lands on the unused slot 31
  always_comb
  begin
    ce_idx = reg_index_t'(`REG_NUM - 1);
    if ($onehot(ce_sel))
    begin
      for (int i = 0; i < `REG_NUM; i++)
      begin
        if (ce_sel[`REG_NUM-1-i])
          ce_idx = reg_index_t'(i);
      end
    end
  end

  always_comb
  begin
    case (idx_q)
      reg_index_t'(`REG_LEN):   rd_mux = status.len;
      reg_index_t'(`REG_BASE):  rd_mux = status.base;
      reg_index_t'(`REG_COUNT): rd_mux = status.count;
      reg_index_t'(`REG_LEVEL): rd_mux = `DATA_W'(status.level);
      default:                  rd_mux = '0;
    endcase
  end

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      sel_q      <= 1'b0;
      sel_d      <= 1'b0;
      sel_2d     <= 1'b0;
      rd_q       <= 1'b0;
      bus_wr_ack <= 1'b0;
      bus_rd_ack <= 1'b0;
    end
    else
    begin
      sel_q  <= |ce_sel;
      sel_d  <= sel_q;
      sel_2d <= sel_d;
      if (ce_first)
        rd_q <= |bus_rd_ce;
      bus_wr_ack <= ack_s & ~rd_q;
      bus_rd_ack <= ack_s & rd_q;
    end
  end

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (ce_first)
    begin
      idx_q   <= ce_idx;
      wdata_q <= bus_wdata;
    end
    bus_rdata <= rd_mux;
  end

  // Write strobe lines up with the write acknowledge
  assign reg_wr = '{wr: bus_wr_ack, idx: idx_q, data: wdata_q};

  // Host drives one access type at a time
  a_ce_exclusive: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    !((|bus_wr_ce) && (|bus_rd_ce)));

endmodule

/* hw/buffer_sequencer.sv */
`include "dma_rearm_defines.svh"

module buffer_sequencer
  import dma_rearm_reg_pkg::*;
  import dma_rearm_axi_pkg::*;
(
  input  logic        M_AXI_ACLK,
  input  logic        M_AXI_ARESETN,
  input  reg_write_t  reg_wr,
  input  logic        irq_dma,
  input  logic        desc_busy,
  output logic        desc_start,
  output desc_req_t   desc,
  output seq_status_t status
);

  localparam int PTR_W = $clog2(`QUEUE_DEPTH);

  logic [`DATA_W-1:0]   len_q;
  logic [`ADDR_W-1:0]   base_q;
  logic [`DATA_W-1:0]   count_q;
  logic [`ADDR_W-1:0]   queue_mem [`QUEUE_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [3:0]           level_q;
  logic                 irq_ff1;
  logic                 irq_ff2;
  logic                 irq_d;
  logic                 irq_pulse;
  logic                 push;
  logic                 pop;
  logic                 launch;
  logic                 wrap;
  logic [`DATA_W-1:0]   blk_off;
  logic [2*`DATA_W-1:0] next_off;

  //////////////////////////////
  // Interrupt edge
  //////////////////////////////
  assign irq_pulse = irq_ff2 & ~irq_d;

  // A push to a full queue is dropped
  assign push = reg_wr.wr && (reg_wr.idx == reg_index_t'(`REG_PUSH)) &&
                (level_q != 4'(`QUEUE_DEPTH));
  assign pop  = (base_q == '0) && (level_q != '0);

  // Busy writer or empty base swallows the interrupt
  assign launch = irq_pulse && !desc_busy && !desc_start && (base_q != '0);

  //////////////////////////////
  // Window stepping
  //////////////////////////////
  assign blk_off  = {len_q[`DATA_W-3:0], 2'b00} * count_q;
  assign next_off = {len_q, 2'b00} * (count_q + 1);
  assign wrap     = next_off >= `WINDOW_BYTES;

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      irq_ff1    <= 1'b0;
      irq_ff2    <= 1'b0;
      irq_d      <= 1'b0;
      len_q      <= '0;
      base_q     <= '0;
      count_q    <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      level_q    <= '0;
      desc_start <= 1'b0;
    end
    else
    begin
      irq_ff1    <= irq_dma;
      irq_ff2    <= irq_ff1;
      irq_d      <= irq_ff2;
      desc_start <= launch;
      if (reg_wr.wr && (reg_wr.idx == reg_index_t'(`REG_LEN)))
        len_q <= reg_wr.data;
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
      begin
        base_q <= queue_mem[rd_ptr];
        rd_ptr <= rd_ptr + 1'b1;
      end
      else if (launch && wrap)
        base_q <= '0;
      if (launch)
        count_q <= wrap ? '0 : count_q + 1'b1;
      level_q <= level_q + 4'(push) - 4'(pop);
    end
  end

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (push)
      queue_mem[wr_ptr] <= reg_wr.data;
    if (launch)
      desc <= '{addr: base_q + blk_off, len_words: len_q};
  end

  assign status = '{len: len_q, base: base_q, count: count_q, level: level_q};

  // Level stays in range and agrees with the pointer distance
  a_level_bound: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    (level_q <= 4'(`QUEUE_DEPTH)) && (level_q[PTR_W-1:0] == PTR_W'(wr_ptr - rd_ptr)));

endmodule

/* hw/descriptor_writer.sv */
`include "dma_rearm_defines.svh"

module descriptor_writer
  import dma_rearm_axi_pkg::*;
(
  input  logic           M_AXI_ACLK,
  input  logic           M_AXI_ARESETN,
  input  logic           desc_start,
  input  desc_req_t      desc,
  input  axi_write_rsp_t axi_rsp,
  output axi_write_req_t axi_req,
  output logic           desc_busy
);

  localparam int IDX_W = $clog2(`DESC_COUNT + 1);

  desc_req_t          desc_q;
  logic [IDX_W-1:0]   idx_q;
  logic               issue_q;
  logic               awvalid_q;
  logic               wvalid_q;
  logic               bready_q;
  logic [`ADDR_W-1:0] wr_addr;
  logic [`DATA_W-1:0] wr_data;
  logic [`DATA_W-1:0] kick_word;

  // Burst size in 8-byte beats, minus one, on top of the kick bit
  assign kick_word = ({desc_q.len_words[`DATA_W-3:0], 2'b00} >> 3) - 1 + `DESC_KICK_BASE;

  //////////////////////////////
  // Descriptor program
  //////////////////////////////
  always_comb
  begin
    case (idx_q)
      IDX_W'(0): wr_addr = `DESC_ADDR_0;
      IDX_W'(1): wr_addr = `DESC_ADDR_1;
      IDX_W'(2): wr_addr = `DESC_ADDR_2;
      IDX_W'(3): wr_addr = `DESC_ADDR_3;
      IDX_W'(4): wr_addr = `DESC_ADDR_4;
      IDX_W'(5): wr_addr = `DESC_ADDR_5;
      default:   wr_addr = '0;
    endcase
  end

  always_comb
  begin
    case (idx_q)
      IDX_W'(1): wr_data = `DESC_CTRL_A;
      IDX_W'(2): wr_data = `DESC_CTRL_B;
      IDX_W'(3): wr_data = desc_q.addr;
      IDX_W'(4): wr_data = `DESC_MASK;
      IDX_W'(5): wr_data = kick_word;
      default:   wr_data = '0;
    endcase
  end

  //////////////////////////////
  // AW / W / B handshakes
  //////////////////////////////
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      desc_busy <= 1'b0;
      idx_q     <= '0;
      issue_q   <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      bready_q  <= 1'b0;
    end
    else
    begin
      issue_q <= 1'b0;
      if (desc_start)
      begin
        desc_busy <= 1'b1;
        idx_q     <= '0;
        awvalid_q <= 1'b1;
        wvalid_q  <= 1'b1;
        bready_q  <= 1'b1;
      end
      else if (issue_q)
      begin
        // Index past the last write closes the descriptor
        if (idx_q == IDX_W'(`DESC_COUNT))
          desc_busy <= 1'b0;
        else
        begin
          awvalid_q <= 1'b1;
          wvalid_q  <= 1'b1;
          bready_q  <= 1'b1;
        end
      end
      else
      begin
        if (awvalid_q && axi_rsp.awready)
          awvalid_q <= 1'b0;
        if (wvalid_q && axi_rsp.wready)
          wvalid_q <= 1'b0;
        if (bready_q && axi_rsp.bvalid)
        begin
          bready_q <= 1'b0;
          idx_q    <= idx_q + 1'b1;
          issue_q  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (desc_start)
      desc_q <= desc;
  end

  assign axi_req = '{awaddr: wr_addr, awvalid: awvalid_q, wdata: wr_data,
                     wvalid: wvalid_q, bready: bready_q};

  a_start_idle: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    desc_start |-> !desc_busy);

endmodule

/* hw/dma_rearm_top.sv */
`include "dma_rearm_defines.svh"

module dma_rearm_top
  import dma_rearm_reg_pkg::*;
  import dma_rearm_axi_pkg::*;
(
  input  logic                 M_AXI_ACLK,
  input  logic                 M_AXI_ARESETN,
  input  logic [`REG_NUM-1:0]  bus_wr_ce,
  input  logic [`REG_NUM-1:0]  bus_rd_ce,
  input  logic [`DATA_W-1:0]   bus_wdata,
  output logic [`DATA_W-1:0]   bus_rdata,
  output logic                 bus_wr_ack,
  output logic                 bus_rd_ack,
  input  logic                 IRQ_DMA,
  output logic [`ADDR_W-1:0]   M_AXI_AWADDR,
  output logic [2:0]           M_AXI_AWPROT,
  output logic                 M_AXI_AWVALID,
  output logic [`DATA_W-1:0]   M_AXI_WDATA,
  output logic [`DATA_W/8-1:0] M_AXI_WSTRB,
  output logic                 M_AXI_WVALID,
  output logic                 M_AXI_BREADY,
  input  logic                 M_AXI_AWREADY,
  input  logic                 M_AXI_WREADY,
  input  logic                 M_AXI_BVALID,
  input  logic [1:0]           M_AXI_BRESP
);

  reg_write_t     reg_wr;
  seq_status_t    status;
  desc_req_t      desc;
  logic           desc_start;
  logic           desc_busy;
  axi_write_req_t axi_req;
  axi_write_rsp_t axi_rsp;

  // AXI port packing
  assign axi_rsp = '{awready: M_AXI_AWREADY, wready: M_AXI_WREADY,
                     bvalid: M_AXI_BVALID, bresp: M_AXI_BRESP};
  assign M_AXI_AWADDR  = axi_req.awaddr;
  assign M_AXI_AWVALID = axi_req.awvalid;
  assign M_AXI_WDATA   = axi_req.wdata;
  assign M_AXI_WVALID  = axi_req.wvalid;
  assign M_AXI_BREADY  = axi_req.bready;
  assign M_AXI_AWPROT  = 3'b000;
  assign M_AXI_WSTRB   = '1;

  reg_decode u_reg_decode (.*);

  buffer_sequencer u_buffer_sequencer (.*, .irq_dma(IRQ_DMA));

  descriptor_writer u_descriptor_writer (.*);

endmodule

/* tb/axi_lite_responder.sv */
`include "dma_rearm_defines.svh"

module axi_lite_responder #(
  parameter logic [31:0] SEED = 32'h0
)
(
  input  logic               clk,
  input  logic [`ADDR_W-1:0] awaddr,
  input  logic               awvalid,
  output logic               awready,
  input  logic [`DATA_W-1:0] wdata,
  input  logic               wvalid,
  output logic               wready,
  output logic               bvalid,
  input  logic               bready,
  output logic [1:0]         bresp
);
  timeunit 1ns;
  timeprecision 100ps;

  // Accepted writes with the handshake flag above address and data
  logic [`ADDR_W+`DATA_W:0] wr_log [$];
  integer                   seed;
  logic [`ADDR_W-1:0]       addr_q;
  logic [`DATA_W-1:0]       data_q;
  logic                     hold_ok;
  int                       aw_delay;
  int                       w_delay;
  int                       b_delay;

  // Outputs move 2 ns after the edge
  task automatic next_edge(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  initial
  begin
    seed    = SEED;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = 2'b00;
    forever
    begin
      next_edge(1);
      if (awvalid === 1'b1)
      begin
        aw_delay = $random(seed) & 3;
        w_delay  = $random(seed) & 3;
        b_delay  = $random(seed) & 3;
        hold_ok  = 1'b1;
        fork
          begin
            next_edge(aw_delay);
            // Each valid must still be up when its ready rises
            if (awvalid !== 1'b1)
              hold_ok = 1'b0;
            addr_q  = awaddr;
            awready = 1'b1;
            next_edge(1);
            awready = 1'b0;
          end
          begin
            next_edge(w_delay);
            if (wvalid !== 1'b1)
              hold_ok = 1'b0;
            data_q = wdata;
            wready = 1'b1;
            next_edge(1);
            wready = 1'b0;
          end
        join
        next_edge(b_delay);
        if (bready !== 1'b1)
          hold_ok = 1'b0;
        bvalid = 1'b1;
        next_edge(1);
        bvalid = 1'b0;
        wr_log.push_back({hold_ok, addr_q, data_q});
      end
    end
  end

endmodule

/* tb/tb_dma_rearm.sv */
`include "dma_rearm_defines.svh"

module tb_dma_rearm;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED = 32'h581a_60a2;
  localparam int ACK_TIMEOUT  = 16;
  localparam int DESC_TIMEOUT = 200;
  localparam int IDLE_WINDOW  = 40;
  localparam int MAX_BLOCKS   = 64;

  logic                 M_AXI_ACLK;
  logic                 M_AXI_ARESETN;
  logic [`REG_NUM-1:0]  bus_wr_ce;
  logic [`REG_NUM-1:0]  bus_rd_ce;
  logic [`DATA_W-1:0]   bus_wdata;
  logic [`DATA_W-1:0]   bus_rdata;
  logic                 bus_wr_ack;
  logic                 bus_rd_ack;
  logic                 IRQ_DMA;
  logic [`ADDR_W-1:0]   M_AXI_AWADDR;
  logic [2:0]           M_AXI_AWPROT;
  logic                 M_AXI_AWVALID;
  logic [`DATA_W-1:0]   M_AXI_WDATA;
  logic [`DATA_W/8-1:0] M_AXI_WSTRB;
  logic                 M_AXI_WVALID;
  logic                 M_AXI_BREADY;
  logic                 M_AXI_AWREADY;
  logic                 M_AXI_WREADY;
  logic                 M_AXI_BVALID;
  logic [1:0]           M_AXI_BRESP;

  integer      seed;
  int          check_count;
  int          err_count;
  int          timeout_count;
  // Reference model state
  logic [31:0] m_len;
  logic [31:0] m_base;
  logic [31:0] m_count;
  logic [31:0] m_queue [$];
  logic [31:0] rdata;
  logic [31:0] value;
  int          edges;
  int          blocks;
  logic        aw_seen;

  dma_rearm_top DUT (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .bus_wr_ce     (bus_wr_ce),
    .bus_rd_ce     (bus_rd_ce),
    .bus_wdata     (bus_wdata),
    .bus_rdata     (bus_rdata),
    .bus_wr_ack    (bus_wr_ack),
    .bus_rd_ack    (bus_rd_ack),
    .IRQ_DMA       (IRQ_DMA),
    .M_AXI_AWADDR  (M_AXI_AWADDR),
    .M_AXI_AWPROT  (M_AXI_AWPROT),
    .M_AXI_AWVALID (M_AXI_AWVALID),
    .M_AXI_WDATA   (M_AXI_WDATA),
    .M_AXI_WSTRB   (M_AXI_WSTRB),
    .M_AXI_WVALID  (M_AXI_WVALID),
    .M_AXI_BREADY  (M_AXI_BREADY),
    .M_AXI_AWREADY (M_AXI_AWREADY),
    .M_AXI_WREADY  (M_AXI_WREADY),
    .M_AXI_BVALID  (M_AXI_BVALID),
    .M_AXI_BRESP   (M_AXI_BRESP)
  );

  axi_lite_responder #(.SEED(SEED)) responder (
    .clk     (M_AXI_ACLK),
    .awaddr  (M_AXI_AWADDR),
    .awvalid (M_AXI_AWVALID),
    .awready (M_AXI_AWREADY),
    .wdata   (M_AXI_WDATA),
    .wvalid  (M_AXI_WVALID),
    .wready  (M_AXI_WREADY),
    .bvalid  (M_AXI_BVALID),
    .bready  (M_AXI_BREADY),
    .bresp   (M_AXI_BRESP)
  );

  initial
  begin
    M_AXI_ACLK = 1'b0;
    forever #10 M_AXI_ACLK = ~M_AXI_ACLK;
  end

  task automatic wait_cycles(input int n);
    repeat (n)
    begin
      @(posedge M_AXI_ACLK);
      #2;
    end
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected)
    begin
      $display("ERR %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      err_count++;
    end
  endtask

  task automatic report_timeout(input string what, input int cycles);
    $display("Timed out after %0d cycles waiting for %s", cycles, what);
    timeout_count++;
  endtask

  //////////////////////////////
  // Host register port
  //////////////////////////////
  task automatic host_access(input logic rd, input int idx, input logic [31:0] wdata,
                             output logic [31:0] data, output int lat);
    logic [`REG_NUM-1:0] ce;
    logic                acked;
    int                  n;
    // Register 0 sits on the top chip-enable bit
    ce    = `REG_NUM'(1) << (`REG_NUM - 1 - idx);
    acked = 1'b0;
    n     = 0;
    data  = '0;
    if (rd)
      bus_rd_ce = ce;
    else
    begin
      bus_wr_ce = ce;
      bus_wdata = wdata;
    end
    while (!acked && n < ACK_TIMEOUT)
    begin
      wait_cycles(1);
      n++;
      if (rd ? bus_rd_ack : bus_wr_ack)
      begin
        acked = 1'b1;
        data  = bus_rdata;
      end
    end
    bus_rd_ce = '0;
    bus_wr_ce = '0;
    if (!acked)
      report_timeout("host acknowledge", n);
    // First edge samples the chip enable
    lat = n - 1;
    wait_cycles(1);
  endtask

  task automatic read_check(input int idx, input logic [31:0] expected, input string what);
    logic [31:0] data;
    int          lat;
    host_access(1'b1, idx, '0, data, lat);
    check_value(data, expected, what);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  task automatic model_refill();
    if (m_base == '0 && m_queue.size() > 0)
      m_base = m_queue.pop_front();
  endtask

  task automatic model_push(input logic [31:0] base);
    if (m_queue.size() < `QUEUE_DEPTH)
      m_queue.push_back(base);
    model_refill();
  endtask

  task automatic model_step();
    if (longint'(m_len) * 4 * (m_count + 1) >= `WINDOW_BYTES)
    begin
      m_base  = '0;
      m_count = '0;
      model_refill();
    end
    else
      m_count = m_count + 1;
  endtask

  // One interrupt, six writes checked in order
  task automatic run_descriptor();
    logic [31:0] exp_addr [`DESC_COUNT];
    logic [31:0] exp_data [`DESC_COUNT];
    logic [64:0] entry;
    int          n;
    exp_addr[0] = `DESC_ADDR_0;
    exp_addr[1] = `DESC_ADDR_1;
    exp_addr[2] = `DESC_ADDR_2;
    exp_addr[3] = `DESC_ADDR_3;
    exp_addr[4] = `DESC_ADDR_4;
    exp_addr[5] = `DESC_ADDR_5;
    exp_data[0] = '0;
    exp_data[1] = `DESC_CTRL_A;
    exp_data[2] = `DESC_CTRL_B;
    exp_data[3] = m_base + m_len * 4 * m_count;
    exp_data[4] = `DESC_MASK;
    exp_data[5] = (m_len * 4) / 8 - 1 + `DESC_KICK_BASE;
    IRQ_DMA = 1'b1;
    n = 0;
    while (responder.wr_log.size() < `DESC_COUNT && n < DESC_TIMEOUT)
    begin
      wait_cycles(1);
      n++;
    end
    IRQ_DMA = 1'b0;
    if (responder.wr_log.size() < `DESC_COUNT)
      report_timeout("six descriptor writes", n);
    // Interrupt low long enough to clear the synchronizer
    wait_cycles(4);
    check_value(responder.wr_log.size(), `DESC_COUNT, "writes per interrupt");
    for (int i = 0; i < `DESC_COUNT; i++)
    begin
      if (responder.wr_log.size() > 0)
      begin
        entry = responder.wr_log.pop_front();
        check_value(entry[64], 1'b1, $sformatf("write %0d valid held until ready", i));
        check_value(entry[63:32], exp_addr[i], $sformatf("write %0d address", i));
        check_value(entry[31:0], exp_data[i], $sformatf("write %0d data", i));
      end
    end
    responder.wr_log.delete();
    model_step();
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial
  begin
    seed          = SEED;
    check_count   = 0;
    err_count     = 0;
    timeout_count = 0;
    m_len         = '0;
    m_base        = '0;
    m_count       = '0;
    bus_wr_ce     = '0;
    bus_rd_ce     = '0;
    bus_wdata     = '0;
    IRQ_DMA       = 1'b0;
    M_AXI_ARESETN = 1'b0;
    repeat (8) @(posedge M_AXI_ACLK);
    #2;
    M_AXI_ARESETN = 1'b1;
    wait_cycles(2);

    // Idle handshakes and fixed AXI fields out of reset
    check_value({M_AXI_AWVALID, M_AXI_WVALID, M_AXI_BREADY, bus_wr_ack, bus_rd_ack}, '0,
                "handshake outputs after reset");
    check_value(M_AXI_AWPROT, 3'b000, "AWPROT");
    check_value(M_AXI_WSTRB, 4'hF, "WSTRB");

    // Even length, window closes after two to four blocks
    value = (($random(seed) & 32'h0007_FFFF) + 32'h0004_0000) & ~32'h1;
    host_access(1'b0, `REG_LEN, value, rdata, edges);
    m_len = value;
    host_access(1'b1, `REG_LEN, '0, rdata, edges);
    check_value(rdata, m_len, "length read back");
    check_value(edges, 2, "read acknowledge latency");

    // Two pushes more than the queue holds
    for (int i = 0; i < `QUEUE_DEPTH + 2; i++)
    begin
      value = ($random(seed) & 32'hFFF0_0000) | 32'h0010_0000;
      host_access(1'b0, `REG_PUSH, value, rdata, edges);
      model_push(value);
      read_check(`REG_LEVEL, m_queue.size(), "queue level after push");
      read_check(`REG_BASE, m_base, "current base after push");
    end

    blocks = 0;
    while (m_base != '0 && blocks < MAX_BLOCKS && timeout_count == 0)
    begin
      run_descriptor();
      read_check(`REG_COUNT, m_count, "block count");
      read_check(`REG_BASE, m_base, "current base");
      read_check(`REG_LEVEL, m_queue.size(), "queue level");
      blocks++;
    end

    // Nothing loaded, the interrupt is swallowed
    read_check(`REG_BASE, '0, "base after drain");
    read_check(`REG_LEVEL, '0, "level after drain");
    aw_seen = 1'b0;
    IRQ_DMA = 1'b1;
    for (int i = 0; i < IDLE_WINDOW; i++)
    begin
      wait_cycles(1);
      if (M_AXI_AWVALID)
        aw_seen = 1'b1;
    end
    IRQ_DMA = 1'b0;
    check_value(aw_seen, 1'b0, "AWVALID with no base loaded");
    check_value(responder.wr_log.size(), 0, "writes with no base loaded");

    $display("checks %0d, mismatches %0d, timeouts %0d, blocks %0d",
             check_count, err_count, timeout_count, blocks);
    if (err_count == 0 && timeout_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

/* build.f */
+incdir+hw
hw/dma_rearm_reg_pkg.sv
hw/dma_rearm_axi_pkg.sv
hw/reg_decode.sv
hw/buffer_sequencer.sv
hw/descriptor_writer.sv
hw/dma_rearm_top.sv
tb/axi_lite_responder.sv
tb/tb_dma_rearm.sv
